//--- verilog/lsu_pkg.sv
package lsu_pkg;

  // Data and address word
  typedef logic [31:0] xlen_t;

  // Register file index
  typedef logic [4:0] reg_idx_t;

  // Access size and sign, RISC-V funct3 encoding
  typedef logic [2:0] funct3_t;

  // One strobe per byte lane
  typedef logic [3:0] strb_t;

  // Signed accesses, shared by loads and stores
  localparam funct3_t F3_B = 3'd0;
  localparam funct3_t F3_H = 3'd1;
  localparam funct3_t F3_W = 3'd2;

  // Unsigned loads only
  localparam funct3_t F3_BU = 3'd4;
  localparam funct3_t F3_HU = 3'd5;

  // Size field, the low two bits of funct3
  localparam logic [1:0] SIZE_B = 2'b00;
  localparam logic [1:0] SIZE_H = 2'b01;
  localparam logic [1:0] SIZE_W = 2'b10;

  // Kind of operation entering the pipeline
  typedef enum logic [1:0] {
    OP_ADDR  = 2'd0,
    OP_LOAD  = 2'd1,
    OP_STORE = 2'd2
  } op_e;

  // Source of the value written back to rd
  typedef enum logic {
    RES_ALU  = 1'b0,
    RES_LOAD = 1'b1
  } res_src_e;

  // Trap cause reported with the writeback
  typedef enum logic [1:0] {
    TRAP_NONE          = 2'd0,
    TRAP_LDST_MISALIGN = 2'd1
  } trap_code_e;

endpackage

//--- verilog/ex_mem_if.sv
`timescale 1ns/1ps

// One operation travelling from EX to MEM
interface ex_mem_if import lsu_pkg::*; ();
  logic     valid;
  op_e      op;
  funct3_t  funct3;
  reg_idx_t rd;
  // Effective address, byte granular
  xlen_t    addr;
  xlen_t    store_data;

  modport ex(output valid, op, funct3, rd, addr, store_data);
  modport mem(input valid, op, funct3, rd, addr, store_data);
endinterface

// One operation travelling from MEM to WB
interface mem_wb_if import lsu_pkg::*; ();
  logic       valid;
  logic       reg_write;
  reg_idx_t   rd;
  res_src_e   res_src;
  xlen_t      alu_result;
  // Already extended and shifted down to bit 0
  xlen_t      load_data;
  logic       trap;
  trap_code_e trap_code;

  modport mem(output valid, reg_write, rd, res_src, alu_result, load_data, trap, trap_code);
  modport wb(input valid, reg_write, rd, res_src, alu_result, load_data, trap, trap_code);
endinterface

//--- verilog/store_fmt.sv
`timescale 1ns/1ps

module store_fmt import lsu_pkg::*; (
  input  xlen_t      data,
  input  logic [1:0] addr_lsb,
  input  funct3_t    funct3,
  output xlen_t      wdata,
  output strb_t      wstrb
);

  // Replicating the low bits puts the value in every lane,
  // so the strobes alone pick the lanes that are written
  always_comb begin
    case (funct3[1:0])
      SIZE_B: begin
        wdata = {4{data[7:0]}};
        // One lane, chosen by the byte offset
        wstrb = strb_t'(4'b0001 << addr_lsb);
      end
      SIZE_H: begin
        wdata = {2{data[15:0]}};
        // Lower or upper halfword
        if (addr_lsb[1]) begin
          wstrb = 4'b1100;
        end else begin
          wstrb = 4'b0011;
        end
      end
      SIZE_W: begin
        wdata = data;
        wstrb = 4'b1111;
      end
      default: begin
        // Not a valid store size, nothing written
        wdata = data;
        wstrb = 4'b0000;
      end
    endcase
  end

endmodule

//--- verilog/load_fmt.sv
`timescale 1ns/1ps

module load_fmt import lsu_pkg::*; (
  input  xlen_t      rdata,
  input  logic [1:0] addr_lsb,
  input  funct3_t    funct3,
  output xlen_t      data
);

  // Read word moved down so the addressed byte sits at bit 0
  xlen_t shifted;

  // Byte offset times eight
  assign shifted = rdata >> {addr_lsb, 3'b000};

  always_comb begin
    case (funct3)
      // Signed byte
      F3_B: begin
        data = {{24{shifted[7]}}, shifted[7:0]};
      end
      // Signed halfword
      F3_H: begin
        data = {{16{shifted[15]}}, shifted[15:0]};
      end
      // Unsigned byte
      F3_BU: begin
        data = {24'b0, shifted[7:0]};
      end
      // Unsigned halfword
      F3_HU: begin
        data = {16'b0, shifted[15:0]};
      end
      // Word and anything else pass through as read
      default: begin
        data = rdata;
      end
    endcase
  end

endmodule

//--- verilog/stage_ex.sv
`timescale 1ns/1ps

module stage_ex import lsu_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     stall,
  input  logic     in_valid,
  input  op_e      in_op,
  input  funct3_t  in_funct3,
  input  reg_idx_t in_rd,
  input  xlen_t    in_base,
  input  xlen_t    in_offset,
  input  xlen_t    in_store_data,
  ex_mem_if.ex     ex_mem
);

  // Input register contents
  logic     valid_q;
  op_e      op_q;
  funct3_t  funct3_q;
  reg_idx_t rd_q;
  xlen_t    base_q;
  xlen_t    offset_q;
  xlen_t    store_data_q;

  // Effective address, also the result of an address operation
  xlen_t    eff_addr;

  // Input valid bit
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (!stall) begin
      valid_q <= in_valid;
    end
  end

  // Payload follows the source whenever the pipeline moves
  always_ff @(posedge clk) begin
    if (!stall) begin
      op_q         <= in_op;
      funct3_q     <= in_funct3;
      rd_q         <= in_rd;
      base_q       <= in_base;
      offset_q     <= in_offset;
      store_data_q <= in_store_data;
    end
  end

  assign eff_addr = base_q + offset_q;

  // An empty slot moves on to MEM with valid low
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_mem.valid <= 1'b0;
    end else if (!stall) begin
      ex_mem.valid <= valid_q;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      ex_mem.op         <= op_q;
      ex_mem.funct3     <= funct3_q;
      ex_mem.rd         <= rd_q;
      ex_mem.addr       <= eff_addr;
      ex_mem.store_data <= store_data_q;
    end
  end

endmodule

//--- verilog/stage_mem.sv
`timescale 1ns/1ps

module stage_mem import lsu_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    stall,
  ex_mem_if.mem   ex_mem,
  output logic    dmem_ren,
  output xlen_t   dmem_raddr,
  input  xlen_t   dmem_rdata,
  output logic    dmem_we,
  output xlen_t   dmem_waddr,
  output xlen_t   dmem_wdata,
  output strb_t   dmem_wstrb,
  mem_wb_if.mem   mem_wb
);

  logic     is_load;
  logic     is_store;
  logic     misalign;
  xlen_t    word_addr;
  xlen_t    load_data;
  res_src_e res_src;

  assign is_load  = ex_mem.valid && (ex_mem.op == OP_LOAD);
  assign is_store = ex_mem.valid && (ex_mem.op == OP_STORE);

  // Halfword must be even, word must be 4-byte aligned
  // Address operations never trap
  always_comb begin
    misalign = 1'b0;
    if (is_load || is_store) begin
      case (ex_mem.funct3[1:0])
        SIZE_H:  misalign = ex_mem.addr[0];
        SIZE_W:  misalign = |ex_mem.addr[1:0];
        default: misalign = 1'b0;
      endcase
    end
  end

  // SRAM sees word addresses, lanes are picked by strobes
  assign word_addr = {ex_mem.addr[31:2], 2'b00};

  // Trapped accesses never reach the SRAM
  assign dmem_ren   = is_load && !misalign;
  assign dmem_raddr = word_addr;

  // Write held off while frozen, the store commits on the edge it leaves MEM
  assign dmem_we    = is_store && !misalign && !stall;
  assign dmem_waddr = word_addr;

  store_fmt u_store_fmt (
    .data     (ex_mem.store_data),
    .addr_lsb (ex_mem.addr[1:0]),
    .funct3   (ex_mem.funct3),
    .wdata    (dmem_wdata),
    .wstrb    (dmem_wstrb)
  );

  // Read data comes back in this cycle, formatted before the register
  load_fmt u_load_fmt (
    .rdata    (dmem_rdata),
    .addr_lsb (ex_mem.addr[1:0]),
    .funct3   (ex_mem.funct3),
    .data     (load_data)
  );

  assign res_src = (ex_mem.op == OP_LOAD) ? RES_LOAD : RES_ALU;

  // MEM/WB control bits
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mem_wb.valid     <= 1'b0;
      mem_wb.reg_write <= 1'b0;
      mem_wb.trap      <= 1'b0;
    end else if (!stall) begin
      mem_wb.valid     <= ex_mem.valid;
      // Stores and trapped operations leave rd alone
      mem_wb.reg_write <= ex_mem.valid && (ex_mem.op != OP_STORE) && !misalign;
      mem_wb.trap      <= misalign;
    end
  end

  // MEM/WB payload
  always_ff @(posedge clk) begin
    if (!stall) begin
      mem_wb.rd         <= ex_mem.rd;
      mem_wb.res_src    <= res_src;
      mem_wb.alu_result <= ex_mem.addr;
      mem_wb.load_data  <= load_data;
      mem_wb.trap_code  <= misalign ? TRAP_LDST_MISALIGN : TRAP_NONE;
    end
  end

endmodule

//--- verilog/stage_wb.sv
`timescale 1ns/1ps

module stage_wb import lsu_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       stall,
  mem_wb_if.wb       mem_wb,
  output logic       wb_valid,
  output logic       wb_we,
  output reg_idx_t   wb_rd,
  output xlen_t      wb_data,
  output logic       wb_trap,
  output trap_code_e wb_trap_code
);

  xlen_t result;
  logic  rd_zero;

  assign result  = (mem_wb.res_src == RES_LOAD) ? mem_wb.load_data : mem_wb.alu_result;
  // x0 is hardwired, never written
  assign rd_zero = (mem_wb.rd == '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_valid <= 1'b0;
      wb_we    <= 1'b0;
      wb_trap  <= 1'b0;
    end else if (!stall) begin
      wb_valid <= mem_wb.valid;
      wb_we    <= mem_wb.valid && mem_wb.reg_write && !rd_zero;
      wb_trap  <= mem_wb.valid && mem_wb.trap;
    end else begin
      // Frozen pipeline, drop the beat so it is not reported again
      wb_valid <= 1'b0;
      wb_we    <= 1'b0;
      wb_trap  <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      wb_rd        <= mem_wb.rd;
      wb_data      <= rd_zero ? '0 : result;
      wb_trap_code <= mem_wb.trap_code;
    end
  end

endmodule

//--- verilog/data_sram.sv
`timescale 1ns/1ps

module data_sram import lsu_pkg::*; #(
  parameter int MEM_WORDS = 256
) (
  input  logic  clk,
  input  logic  ren,
  input  xlen_t raddr,
  output xlen_t rdata,
  input  logic  we,
  input  xlen_t waddr,
  input  xlen_t wdata,
  input  strb_t wstrb
);

  // Word index width, depth is a power of two
  localparam int IDX_W = $clog2(MEM_WORDS);

  xlen_t mem [MEM_WORDS];

  logic [IDX_W-1:0] ridx;
  logic [IDX_W-1:0] widx;

  // Byte address bits above the lane select, upper bits wrap
  assign ridx = raddr[IDX_W+1:2];
  assign widx = waddr[IDX_W+1:2];

  // Combinational read, quiet when not enabled
  assign rdata = ren ? mem[ridx] : '0;

  // Byte-strobed write
  always_ff @(posedge clk) begin
    if (we) begin
      for (int i = 0; i < 4; i++) begin
        if (wstrb[i]) begin
          mem[widx][i*8 +: 8] <= wdata[i*8 +: 8];
        end
      end
    end
  end

endmodule

//--- verilog/lsu_top.sv
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; #(
  parameter int MEM_WORDS = 256
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       in_valid,
  input  op_e        in_op,
  input  funct3_t    in_funct3,
  input  reg_idx_t   in_rd,
  input  xlen_t      in_base,
  input  xlen_t      in_offset,
  input  xlen_t      in_store_data,
  input  logic       stall,
  output logic       wb_valid,
  output logic       wb_we,
  output reg_idx_t   wb_rd,
  output xlen_t      wb_data,
  output logic       wb_trap,
  output trap_code_e wb_trap_code
);

  // Stage to stage links
  ex_mem_if ex_mem ();
  mem_wb_if mem_wb ();

  // Data memory port
  logic  dmem_ren;
  xlen_t dmem_raddr;
  xlen_t dmem_rdata;
  logic  dmem_we;
  xlen_t dmem_waddr;
  xlen_t dmem_wdata;
  strb_t dmem_wstrb;

  stage_ex u_stage_ex (
    .clk           (clk),
    .rst_n         (rst_n),
    .stall         (stall),
    .in_valid      (in_valid),
    .in_op         (in_op),
    .in_funct3     (in_funct3),
    .in_rd         (in_rd),
    .in_base       (in_base),
    .in_offset     (in_offset),
    .in_store_data (in_store_data),
    .ex_mem        (ex_mem.ex)
  );

  stage_mem u_stage_mem (
    .clk        (clk),
    .rst_n      (rst_n),
    .stall      (stall),
    .ex_mem     (ex_mem.mem),
    .dmem_ren   (dmem_ren),
    .dmem_raddr (dmem_raddr),
    .dmem_rdata (dmem_rdata),
    .dmem_we    (dmem_we),
    .dmem_waddr (dmem_waddr),
    .dmem_wdata (dmem_wdata),
    .dmem_wstrb (dmem_wstrb),
    .mem_wb     (mem_wb.mem)
  );

  stage_wb u_stage_wb (
    .clk          (clk),
    .rst_n        (rst_n),
    .stall        (stall),
    .mem_wb       (mem_wb.wb),
    .wb_valid     (wb_valid),
    .wb_we        (wb_we),
    .wb_rd        (wb_rd),
    .wb_data      (wb_data),
    .wb_trap      (wb_trap),
    .wb_trap_code (wb_trap_code)
  );

  data_sram #(
    .MEM_WORDS (MEM_WORDS)
  ) u_data_sram (
    .clk   (clk),
    .ren   (dmem_ren),
    .raddr (dmem_raddr),
    .rdata (dmem_rdata),
    .we    (dmem_we),
    .waddr (dmem_waddr),
    .wdata (dmem_wdata),
    .wstrb (dmem_wstrb)
  );

endmodule

//--- tests/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb import lsu_pkg::*;;

  // Expected writeback of one operation
  typedef struct packed {
    logic       we;
    reg_idx_t   rd;
    logic       trap;
    trap_code_e code;
    logic       chk_data;
    xlen_t      data;
  } exp_t;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       in_valid;
  op_e        in_op;
  funct3_t    in_funct3;
  reg_idx_t   in_rd;
  xlen_t      in_base;
  xlen_t      in_offset;
  xlen_t      in_store_data;
  logic       stall;
  logic       wb_valid;
  logic       wb_we;
  reg_idx_t   wb_rd;
  xlen_t      wb_data;
  logic       wb_trap;
  trap_code_e wb_trap_code;

  // Byte view of the 1 KiB SRAM, only the low 64 bytes are used
  logic [7:0] ref_mem [1024];
  // Operations in flight, oldest first
  exp_t       exp_q [$];
  exp_t       head;
  integer     seed;
  int         n_issued = 0;
  int         cycle_cnt = 0;
  logic       stall_at_edge = 1'b0;
  logic       stall_on = 1'b0;
  logic       gap_on = 1'b0;

  lsu_top #(
    .MEM_WORDS (256)
  ) dut_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .in_valid      (in_valid),
    .in_op         (in_op),
    .in_funct3     (in_funct3),
    .in_rd         (in_rd),
    .in_base       (in_base),
    .in_offset     (in_offset),
    .in_store_data (in_store_data),
    .stall         (stall),
    .wb_valid      (wb_valid),
    .wb_we         (wb_we),
    .wb_rd         (wb_rd),
    .wb_data       (wb_data),
    .wb_trap       (wb_trap),
    .wb_trap_code  (wb_trap_code)
  );

  // 4 ns period
  always #2 clk = ~clk;

  function automatic xlen_t rand_word();
    return $random(seed);
  endfunction

  function automatic int rand_below(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic logic pick_stall();
    return stall_on && (rand_below(4) == 0);
  endfunction

  // Halfwords need an even address, words a multiple of four
  function automatic logic misaligned(funct3_t f3, xlen_t a);
    case (f3)
      F3_H, F3_HU: return a[0];
      F3_W:        return a[1:0] != 2'b00;
      default:     return 1'b0;
    endcase
  endfunction

  // Little endian bytes from the model, then sign or zero fill
  function automatic xlen_t ref_load(funct3_t f3, xlen_t a);
    logic [9:0] idx;
    idx = a[9:0];
    case (f3)
      F3_B:    return {{24{ref_mem[idx][7]}}, ref_mem[idx]};
      F3_BU:   return {24'h0, ref_mem[idx]};
      F3_H:    return {{16{ref_mem[idx + 10'd1][7]}}, ref_mem[idx + 10'd1], ref_mem[idx]};
      F3_HU:   return {16'h0, ref_mem[idx + 10'd1], ref_mem[idx]};
      default: return {ref_mem[idx + 10'd3], ref_mem[idx + 10'd2],
                       ref_mem[idx + 10'd1], ref_mem[idx]};
    endcase
  endfunction

  task automatic apply_store(input funct3_t f3, input xlen_t a, input xlen_t d);
    logic [9:0] idx;
    idx = a[9:0];
    ref_mem[idx] = d[7:0];
    if (f3 != F3_B) begin
      ref_mem[idx + 10'd1] = d[15:8];
    end
    if (f3 == F3_W) begin
      ref_mem[idx + 10'd2] = d[23:16];
      ref_mem[idx + 10'd3] = d[31:24];
    end
  endtask

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopping on first error");
  endtask

  task automatic check_value(input string what, input xlen_t got, input xlen_t want);
    assert (got === want)
      else abort_run($sformatf("FAILED at %0t ns: %s is 0x%08h, expected 0x%08h",
                               $time, what, got, want));
  endtask

  // Expected result at the moment the pipeline takes the operation
  task automatic record_issue(input op_e op, input funct3_t f3, input reg_idx_t rd,
                              input xlen_t base, input xlen_t offset, input xlen_t sdata);
    xlen_t a;
    logic  mis;
    exp_t  e;
    a = base + offset;
    mis = (op != OP_ADDR) && misaligned(f3, a);
    e.rd = rd;
    e.trap = mis;
    e.code = mis ? TRAP_LDST_MISALIGN : TRAP_NONE;
    e.we = (op != OP_STORE) && !mis && (rd != 5'd0);
    // x0 always reads back zero, store data on a live rd is not defined
    e.chk_data = (rd == 5'd0) || (!mis && op != OP_STORE);
    e.data = '0;
    if (rd != 5'd0) begin
      e.data = (op == OP_LOAD) ? ref_load(f3, a) : a;
    end
    if (op == OP_STORE && !mis) begin
      apply_store(f3, a, sdata);
    end
    exp_q.push_back(e);
    n_issued++;
  endtask

  // Holds the operation until an edge with stall low takes it
  task automatic send_op(input op_e op, input funct3_t f3, input reg_idx_t rd,
                         input xlen_t base, input xlen_t offset, input xlen_t sdata);
    logic taken;
    int   gap;
    gap = gap_on ? rand_below(3) : 0;
    repeat (gap) begin
      in_valid = 1'b0;
      stall = pick_stall();
      @(negedge clk);
    end
    in_valid = 1'b1;
    in_op = op;
    in_funct3 = f3;
    in_rd = rd;
    in_base = base;
    in_offset = offset;
    in_store_data = sdata;
    stall = pick_stall();
    taken = 1'b0;
    while (!taken) begin
      @(posedge clk);
      taken = !stall;
      @(negedge clk);
      if (!taken) begin
        stall = pick_stall();
      end
    end
    in_valid = 1'b0;
    record_issue(op, f3, rd, base, offset, sdata);
  endtask

  // Lands on byte loc of the test region, random upper bits wrap away
  task automatic send_at(input op_e op, input funct3_t f3, input reg_idx_t rd,
                         input logic [5:0] loc, input xlen_t sdata);
    xlen_t eff;
    xlen_t base;
    eff = rand_word();
    eff[9:0] = {4'b0000, loc};
    base = rand_word();
    send_op(op, f3, rd, base, eff - base, sdata);
  endtask

  task automatic send_random();
    funct3_t  f3;
    reg_idx_t rd;
    rd = reg_idx_t'(rand_below(32));
    case (rand_below(3))
      0: begin
        send_op(OP_ADDR, funct3_t'(rand_below(8)), rd, rand_word(), rand_word(), rand_word());
      end
      1: begin
        // Code 3 is no load, reuse it as a second LW slot
        f3 = funct3_t'(rand_below(6));
        if (f3 == 3'd3) begin
          f3 = F3_W;
        end
        send_at(OP_LOAD, f3, rd, 6'(rand_below(64)), '0);
      end
      default: begin
        send_at(OP_STORE, funct3_t'(rand_below(3)), rd, 6'(rand_below(64)), rand_word());
      end
    endcase
  endtask

  always @(posedge clk) begin
    stall_at_edge <= stall;
  end

  // Limit grows with the operations issued so far
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > 20 * n_issued + 100) begin
      abort_run("Timeout: the pipeline stopped returning results");
    end
  end

  // Outputs settle after the rising edge, sample them on the falling one
  always @(negedge clk) begin
    if (rst_n) begin
      // A frozen edge never produces a beat
      if (stall_at_edge) begin
        check_value("wb_valid after a stalled edge", xlen_t'(wb_valid), '0);
      end
      if (wb_valid) begin
        assert (exp_q.size() != 0)
          else abort_run("A result came out with no operation outstanding");
        head = exp_q.pop_front();
        check_value("wb_we", xlen_t'(wb_we), xlen_t'(head.we));
        check_value("wb_rd", xlen_t'(wb_rd), xlen_t'(head.rd));
        check_value("wb_trap", xlen_t'(wb_trap), xlen_t'(head.trap));
        check_value("wb_trap_code", xlen_t'(wb_trap_code), xlen_t'(head.code));
        if (head.chk_data) begin
          check_value("wb_data", wb_data, head.data);
        end
      end
    end
  end

  initial begin
    int         i;
    logic [5:0] loc;
    logic [1:0] lane;
    funct3_t    f3;
    seed = 32'h328a_06a4;
    rst_n = 1'b0;
    in_valid = 1'b0;
    in_op = OP_ADDR;
    in_funct3 = '0;
    in_rd = '0;
    in_base = '0;
    in_offset = '0;
    in_store_data = '0;
    stall = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // SRAM powers up unknown, fill the test region first
    for (i = 0; i < 16; i++) begin
      send_at(OP_STORE, F3_W, 5'd1, 6'(i * 4), rand_word());
    end

    // Store of each size, then every load kind on the same word
    for (i = 0; i < 15; i++) begin
      f3 = funct3_t'(i % 3);
      loc = {4'(rand_below(16)), 2'b00};
      lane = 2'(rand_below(4));
      if (f3 == F3_H) begin
        lane[0] = 1'b0;
      end
      if (f3 == F3_W) begin
        lane = 2'b00;
      end
      send_at(OP_STORE, f3, 5'd2, {loc[5:2], lane}, rand_word());
      send_at(OP_LOAD, F3_B, 5'd3, {loc[5:2], 2'(rand_below(4))}, '0);
      send_at(OP_LOAD, F3_BU, 5'd4, {loc[5:2], 2'(rand_below(4))}, '0);
      send_at(OP_LOAD, F3_H, 5'd5, {loc[5:2], 1'(rand_below(2)), 1'b0}, '0);
      send_at(OP_LOAD, F3_HU, 5'd6, {loc[5:2], 1'(rand_below(2)), 1'b0}, '0);
      // Whole word shows the untouched neighbours
      send_at(OP_LOAD, F3_W, 5'd7, loc, '0);
    end

    // Misaligned halfword and word accesses
    send_at(OP_LOAD, F3_H, 5'd8, 6'd5, '0);
    send_at(OP_LOAD, F3_HU, 5'd9, 6'd7, '0);
    send_at(OP_LOAD, F3_W, 5'd10, 6'd10, '0);
    send_at(OP_LOAD, F3_W, 5'd11, 6'd13, '0);
    send_at(OP_STORE, F3_H, 5'd12, 6'd21, rand_word());
    send_at(OP_STORE, F3_W, 5'd13, 6'd22, rand_word());
    send_at(OP_LOAD, F3_W, 5'd14, 6'd20, '0);

    // Address results and x0 targets
    for (i = 0; i < 8; i++) begin
      send_op(OP_ADDR, funct3_t'(rand_below(8)), 5'd15, rand_word(), rand_word(), '0);
    end
    send_op(OP_ADDR, F3_B, 5'd0, rand_word(), rand_word(), '0);
    send_at(OP_LOAD, F3_W, 5'd0, 6'd32, '0);
    send_at(OP_LOAD, F3_H, 5'd0, 6'd33, '0);
    send_at(OP_STORE, F3_B, 5'd0, 6'd40, rand_word());

    // Random mix under stalls and idle gaps
    stall_on = 1'b1;
    gap_on = 1'b1;
    for (i = 0; i < 250; i++) begin
      send_random();
    end
    stall_on = 1'b0;
    stall = 1'b0;

    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    // Quiet tail catches any extra beat
    repeat (5) @(negedge clk);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

//--- all.f
verilog/lsu_pkg.sv
verilog/ex_mem_if.sv
verilog/store_fmt.sv
verilog/load_fmt.sv
verilog/stage_ex.sv
verilog/stage_mem.sv
verilog/stage_wb.sv
verilog/data_sram.sv
verilog/lsu_top.sv
tests/lsu_tb.sv

//--- Bender.yml
package:
  name: lsu

sources:
  - verilog/lsu_pkg.sv
  - verilog/ex_mem_if.sv
  - verilog/store_fmt.sv
  - verilog/load_fmt.sv
  - verilog/stage_ex.sv
  - verilog/stage_mem.sv
  - verilog/stage_wb.sv
  - verilog/data_sram.sv
  - verilog/lsu_top.sv
  - target: test
    files:
      - tests/lsu_tb.sv
